//--- platform_pkg.sv
// shared types and address map; regions are power-of-two sized and aligned, and the UART bit period is fixed at build time
package platform_pkg;

    // bus widths
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    typedef logic [7:0] led_t;
    typedef logic [7:0] uart_byte_t;

    // master to slave
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t addr;
        wb_sel_t  sel;
        wb_data_t wdata;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic     ack;
        logic     err;
        logic     stall;
        wb_data_t rdata;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        SLV_IMEM,
        SLV_DMEM,
        SLV_PERIPH,
        SLV_NONE
    } slave_sel_t;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

    // address map
    localparam wb_addr_t IMEM_BASE = 32'h0000_0000;
    localparam int IMEM_SIZE_WORDS_POT = 10;
    localparam int IMEM_ADDR_POT = IMEM_SIZE_WORDS_POT + 2;

    localparam wb_addr_t DMEM_BASE = 32'h0001_0000;
    localparam int DMEM_SIZE_WORDS_POT = 11;
    localparam int DMEM_ADDR_POT = DMEM_SIZE_WORDS_POT + 2;

    // peripheral window is 4 KiB
    localparam wb_addr_t PERIPH_BASE = 32'h0002_0000;
    localparam int PERIPH_ADDR_POT = 12;
    localparam wb_addr_t PERIPH_LED_OFS = 32'h0;
    localparam wb_addr_t PERIPH_UART_DATA_OFS = 32'h4;
    localparam wb_addr_t PERIPH_UART_STAT_OFS = 32'h8;

    // uart bit timing
    localparam int UART_CLKS_PER_BIT = 8;
    localparam int UART_CNT_W = (UART_CLKS_PER_BIT > 1) ? $clog2(UART_CLKS_PER_BIT) : 1;
    typedef logic [UART_CNT_W-1:0] uart_cnt_t;
    localparam uart_cnt_t UART_CNT_MAX = uart_cnt_t'(UART_CLKS_PER_BIT - 1);

    localparam int RST_SYNC_STAGES = 4;

endpackage : platform_pkg

//--- sp_mem_wb.sv
// word memory without preload, so contents are unknown until written; address bits above the size are ignored
`timescale 1ns/1ps

module sp_mem_wb #(
    parameter int SIZE_POT_WORDS = 10
) (
    input  logic                 sys_clk,
    input  logic                 arst_n_i,
    input  platform_pkg::wb_req_t wb_req_i,
    output platform_pkg::wb_rsp_t wb_rsp_o
);
    import platform_pkg::*;

    wb_data_t mem [2**SIZE_POT_WORDS];

    logic [SIZE_POT_WORDS-1:0] word_addr;
    logic                      accept;
    logic                      ack_q;
    wb_data_t                  rdata_q;

    // byte address to word index
    assign word_addr = wb_req_i.addr[SIZE_POT_WORDS+1:2];

    // never stalls, so every strobe is taken
    assign accept = wb_req_i.cyc && wb_req_i.stb;

    always_ff @(posedge sys_clk)
    begin
        if (accept && wb_req_i.we)
        begin
            for (int i = 0; i < $bits(wb_sel_t); i++)
            begin
                if (wb_req_i.sel[i])
                begin
                    mem[word_addr][i*8 +: 8] <= wb_req_i.wdata[i*8 +: 8];
                end
            end
        end
    end

    // read word captured before any write of the same cycle
    always_ff @(posedge sys_clk)
    begin
        if (accept)
        begin
            rdata_q <= mem[word_addr];
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= accept;
        end
    end

    always_comb
    begin
        wb_rsp_o       = '0;
        wb_rsp_o.ack   = ack_q;
        wb_rsp_o.rdata = rdata_q;
    end

endmodule : sp_mem_wb

//--- wb_decoder.sv
// three-slave pipelined Wishbone router; every slave must answer exactly one cycle after acceptance
`timescale 1ns/1ps

module wb_decoder (
    input  logic                  sys_clk,
    input  logic                  arst_n_i,
    input  platform_pkg::wb_req_t m_req_i,
    output platform_pkg::wb_rsp_t m_rsp_o,
    output platform_pkg::wb_req_t imem_req_o,
    output platform_pkg::wb_req_t dmem_req_o,
    output platform_pkg::wb_req_t periph_req_o,
    input  platform_pkg::wb_rsp_t imem_rsp_i,
    input  platform_pkg::wb_rsp_t dmem_rsp_i,
    input  platform_pkg::wb_rsp_t periph_rsp_i
);
    import platform_pkg::*;

    slave_sel_t dec_sel;
    slave_sel_t rsp_sel_q;
    logic       sel_stall;
    logic       m_accept;
    logic       none_err_q;

    // region match on the bits above each region's size
    always_comb
    begin
        if (m_req_i.addr[31:IMEM_ADDR_POT] == IMEM_BASE[31:IMEM_ADDR_POT])
        begin
            dec_sel = SLV_IMEM;
        end
        else if (m_req_i.addr[31:DMEM_ADDR_POT] == DMEM_BASE[31:DMEM_ADDR_POT])
        begin
            dec_sel = SLV_DMEM;
        end
        else if (m_req_i.addr[31:PERIPH_ADDR_POT] == PERIPH_BASE[31:PERIPH_ADDR_POT])
        begin
            dec_sel = SLV_PERIPH;
        end
        else
        begin
            dec_sel = SLV_NONE;
        end
    end

    // only the target sees stb
    always_comb
    begin
        imem_req_o       = m_req_i;
        dmem_req_o       = m_req_i;
        periph_req_o     = m_req_i;
        imem_req_o.stb   = m_req_i.stb && (dec_sel == SLV_IMEM);
        dmem_req_o.stb   = m_req_i.stb && (dec_sel == SLV_DMEM);
        periph_req_o.stb = m_req_i.stb && (dec_sel == SLV_PERIPH);
    end

    always_comb
    begin
        case (dec_sel)
            SLV_IMEM:   sel_stall = imem_rsp_i.stall;
            SLV_DMEM:   sel_stall = dmem_rsp_i.stall;
            SLV_PERIPH: sel_stall = periph_rsp_i.stall;
            default:    sel_stall = 1'b0;
        endcase
    end

    assign m_accept = m_req_i.cyc && m_req_i.stb && !sel_stall;

    // remember the target of the request now in flight
    always_ff @(posedge sys_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            rsp_sel_q  <= SLV_NONE;
            none_err_q <= 1'b0;
        end
        else
        begin
            if (m_accept)
            begin
                rsp_sel_q <= dec_sel;
            end
            none_err_q <= m_accept && (dec_sel == SLV_NONE);
        end
    end

    // response follows last cycle's target, stall follows the current one
    always_comb
    begin
        m_rsp_o = '0;
        case (rsp_sel_q)
            SLV_IMEM:
            begin
                m_rsp_o.ack   = imem_rsp_i.ack;
                m_rsp_o.err   = imem_rsp_i.err;
                m_rsp_o.rdata = imem_rsp_i.rdata;
            end
            SLV_DMEM:
            begin
                m_rsp_o.ack   = dmem_rsp_i.ack;
                m_rsp_o.err   = dmem_rsp_i.err;
                m_rsp_o.rdata = dmem_rsp_i.rdata;
            end
            SLV_PERIPH:
            begin
                m_rsp_o.ack   = periph_rsp_i.ack;
                m_rsp_o.err   = periph_rsp_i.err;
                m_rsp_o.rdata = periph_rsp_i.rdata;
            end
            default:
            begin
                m_rsp_o.err = none_err_q;
            end
        endcase
        m_rsp_o.stall = sel_stall;
    end

endmodule : wb_decoder

//--- periph_regs.sv
// LED and UART registers; only byte lane 0 is written, and a UART data write stalls while a frame is in progress
`timescale 1ns/1ps

module periph_regs (
    input  logic                     sys_clk,
    input  logic                     arst_n_i,
    input  platform_pkg::wb_req_t    wb_req_i,
    output platform_pkg::wb_rsp_t    wb_rsp_o,
    output platform_pkg::led_t       led_o,
    output logic                     tx_start_o,
    output platform_pkg::uart_byte_t tx_byte_o,
    input  logic                     tx_busy_i
);
    import platform_pkg::*;

    logic       is_led;
    logic       is_data;
    logic       is_stat;
    logic       req_valid;
    logic       uart_wr;
    logic       stall;
    logic       accept;
    wb_data_t   rd_word;
    logic       ack_q;
    wb_data_t   rdata_q;
    led_t       led_q;
    logic       tx_start_q;
    uart_byte_t tx_byte_q;

    // word offset inside the window
    assign is_led  = wb_req_i.addr[PERIPH_ADDR_POT-1:2] == PERIPH_LED_OFS[PERIPH_ADDR_POT-1:2];
    assign is_data = wb_req_i.addr[PERIPH_ADDR_POT-1:2]
                     == PERIPH_UART_DATA_OFS[PERIPH_ADDR_POT-1:2];
    assign is_stat = wb_req_i.addr[PERIPH_ADDR_POT-1:2]
                     == PERIPH_UART_STAT_OFS[PERIPH_ADDR_POT-1:2];

    assign req_valid = wb_req_i.cyc && wb_req_i.stb;
    assign uart_wr   = req_valid && wb_req_i.we && is_data && wb_req_i.sel[0];

    // hold a new byte until the transmitter is free
    assign stall  = uart_wr && tx_busy_i;
    assign accept = req_valid && !stall;

    always_comb
    begin
        rd_word = '0;
        if (is_led)
        begin
            rd_word = wb_data_t'(led_q);
        end
        else if (is_stat)
        begin
            rd_word = wb_data_t'(tx_busy_i);
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ack_q      <= 1'b0;
            led_q      <= '0;
            tx_start_q <= 1'b0;
        end
        else
        begin
            ack_q      <= accept;
            tx_start_q <= accept && uart_wr;
            if (accept && wb_req_i.we && is_led && wb_req_i.sel[0])
            begin
                led_q <= wb_req_i.wdata[7:0];
            end
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (accept)
        begin
            rdata_q   <= rd_word;
            tx_byte_q <= wb_req_i.wdata[7:0];
        end
    end

    always_comb
    begin
        wb_rsp_o       = '0;
        wb_rsp_o.ack   = ack_q;
        wb_rsp_o.stall = stall;
        wb_rsp_o.rdata = rdata_q;
    end

    assign led_o      = led_q;
    assign tx_start_o = tx_start_q;
    assign tx_byte_o  = tx_byte_q;

endmodule : periph_regs

//--- uart_tx.sv
// 8N1 transmitter with a fixed bit period; start_i is ignored while a frame is in progress
`timescale 1ns/1ps

module uart_tx (
    input  logic                     sys_clk,
    input  logic                     arst_n_i,
    input  logic                     start_i,
    input  platform_pkg::uart_byte_t byte_i,
    output logic                     busy_o,
    output logic                     tx_o
);
    import platform_pkg::*;

    uart_state_t state_q;
    uart_cnt_t   cnt_q;
    logic [2:0]  bit_idx_q;
    uart_byte_t  shift_q;
    logic        tx_q;
    logic        bit_end;

    assign bit_end = cnt_q == UART_CNT_MAX;

    always_ff @(posedge sys_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state_q   <= UART_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            tx_q      <= 1'b1;
        end
        else
        begin
            case (state_q)
                UART_IDLE:
                begin
                    cnt_q <= '0;
                    if (start_i)
                    begin
                        state_q <= UART_START;
                        tx_q    <= 1'b0;
                    end
                end
                UART_START:
                begin
                    cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
                    if (bit_end)
                    begin
                        // first data bit is the LSB
                        state_q   <= UART_DATA;
                        bit_idx_q <= '0;
                        tx_q      <= shift_q[0];
                    end
                end
                UART_DATA:
                begin
                    cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
                    if (bit_end)
                    begin
                        if (bit_idx_q == 3'd7)
                        begin
                            state_q <= UART_STOP;
                            tx_q    <= 1'b1;
                        end
                        else
                        begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            tx_q      <= shift_q[1];
                        end
                    end
                end
                default:
                begin
                    cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
                    if (bit_end)
                    begin
                        state_q <= UART_IDLE;
                    end
                end
            endcase
        end
    end

    // load on start, shift once per data bit
    always_ff @(posedge sys_clk)
    begin
        if (state_q == UART_IDLE && start_i)
        begin
            shift_q <= byte_i;
        end
        else if ((state_q == UART_DATA) && bit_end)
        begin
            shift_q <= shift_q >> 1;
        end
    end

    // busy already during the start pulse so the next write stalls
    assign busy_o = (state_q != UART_IDLE) || start_i;
    assign tx_o   = tx_q;

endmodule : uart_tx

//--- soc_top.sv
// bus-side platform top; the external master replaces the CPU, and memories start with unknown contents
`timescale 1ns/1ps

module soc_top (
    input  logic                  sys_clk,
    input  logic                  arst_n_i,
    input  platform_pkg::wb_req_t wb_req_i,
    output platform_pkg::wb_rsp_t wb_rsp_o,
    output platform_pkg::led_t    led_o,
    output logic                  uart_tx_o
);
    import platform_pkg::*;

    logic [RST_SYNC_STAGES-1:0] rst_sync_q;
    logic                       rst_sync_n;

    wb_req_t    imem_req;
    wb_req_t    dmem_req;
    wb_req_t    periph_req;
    wb_rsp_t    imem_rsp;
    wb_rsp_t    dmem_rsp;
    wb_rsp_t    periph_rsp;
    logic       tx_start;
    uart_byte_t tx_byte;
    logic       tx_busy;

    // asserts at once, releases after RST_SYNC_STAGES edges
    always_ff @(posedge sys_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            rst_sync_q <= '0;
        end
        else
        begin
            rst_sync_q <= {rst_sync_q[RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign rst_sync_n = rst_sync_q[RST_SYNC_STAGES-1];

    wb_decoder u_decoder (
        .sys_clk      (sys_clk),
        .arst_n_i     (rst_sync_n),
        .m_req_i      (wb_req_i),
        .m_rsp_o      (wb_rsp_o),
        .imem_req_o   (imem_req),
        .dmem_req_o   (dmem_req),
        .periph_req_o (periph_req),
        .imem_rsp_i   (imem_rsp),
        .dmem_rsp_i   (dmem_rsp),
        .periph_rsp_i (periph_rsp)
    );

    // instruction memory
    sp_mem_wb #(.SIZE_POT_WORDS(IMEM_SIZE_WORDS_POT)) u_imem (
        .sys_clk  (sys_clk),
        .arst_n_i (rst_sync_n),
        .wb_req_i (imem_req),
        .wb_rsp_o (imem_rsp)
    );

    // data memory
    sp_mem_wb #(.SIZE_POT_WORDS(DMEM_SIZE_WORDS_POT)) u_dmem (
        .sys_clk  (sys_clk),
        .arst_n_i (rst_sync_n),
        .wb_req_i (dmem_req),
        .wb_rsp_o (dmem_rsp)
    );

    periph_regs u_periph (
        .sys_clk    (sys_clk),
        .arst_n_i   (rst_sync_n),
        .wb_req_i   (periph_req),
        .wb_rsp_o   (periph_rsp),
        .led_o      (led_o),
        .tx_start_o (tx_start),
        .tx_byte_o  (tx_byte),
        .tx_busy_i  (tx_busy)
    );

    uart_tx u_uart_tx (
        .sys_clk  (sys_clk),
        .arst_n_i (rst_sync_n),
        .start_i  (tx_start),
        .byte_i   (tx_byte),
        .busy_o   (tx_busy),
        .tx_o     (uart_tx_o)
    );

endmodule : soc_top

//--- tb_soc_top.sv
// random Wishbone traffic into soc_top; memory reads check only the byte lanes already written
`timescale 1ns/1ps

module tb_soc_top;
    import platform_pkg::*;

    localparam int TIMEOUT_CYCLES = 1000;

    typedef struct {
        logic     exp_err;
        wb_data_t exp_rdata;
        wb_data_t rd_mask;
        wb_addr_t addr;
        int       due;
    } exp_rsp_t;

    logic    sys_clk;
    logic    arst_n_i;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    led_t    led;
    logic    uart_tx;

    int         cycle_cnt = 0;
    int         data_errs = 0;
    int         proto_errs = 0;
    int         uart_errs = 0;
    int         timeouts = 0;
    int         stall_cycles = 0;
    logic       reset_done = 1'b0;
    exp_rsp_t   rsp_q[$];
    uart_byte_t uart_q[$];
    wb_data_t   mem_model [int];
    wb_sel_t    mem_valid [int];
    led_t       led_model;

    soc_top i_soc_top (
        .sys_clk   (sys_clk),
        .arst_n_i  (arst_n_i),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .led_o     (led),
        .uart_tx_o (uart_tx)
    );

    initial
    begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic end_run();
        $display("errors: data %0d, protocol %0d, uart %0d, timeout %0d",
                 data_errs, proto_errs, uart_errs, timeouts);
        if (data_errs + proto_errs + uart_errs + timeouts == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timeouts++;
        end_run();
    endtask

    function automatic wb_data_t lane_mask(input wb_sel_t sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    // called at posedge + 1 ns, returns at posedge + 1 ns after the accepting edge
    task automatic bus_access(input logic we, input wb_addr_t addr, input wb_sel_t sel,
                              input wb_data_t wdata, input exp_rsp_t e);
        int waited;
        waited = 0;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.addr  = addr;
        wb_req.sel   = sel;
        wb_req.wdata = wdata;
        @(negedge sys_clk);
        while (wb_rsp.stall && waited < TIMEOUT_CYCLES)
        begin
            waited++;
            @(negedge sys_clk);
        end
        if (wb_rsp.stall)
            report_timeout("stall to drop");
        // only a UART data write with lane 0 may be held back
        if (waited > 0 && !(we && sel[0] && addr == PERIPH_BASE + PERIPH_UART_DATA_OFS))
        begin
            $display("access to %h was stalled although it can never be held", addr);
            proto_errs++;
        end
        stall_cycles = waited;
        @(posedge sys_clk);
        #1;
        e.due = cycle_cnt;
        rsp_q.push_back(e);
    endtask

    task automatic bus_idle(input int n);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        repeat (n)
        begin
            @(posedge sys_clk);
            #1;
        end
    endtask

    task automatic mem_write(input wb_addr_t addr, input wb_sel_t sel, input wb_data_t data);
        exp_rsp_t e;
        int       key;
        key = int'(addr >> 2);
        if (!mem_valid.exists(key))
        begin
            mem_model[key] = '0;
            mem_valid[key] = '0;
        end
        // byte-lane merge into the model word
        mem_model[key] = (mem_model[key] & ~lane_mask(sel)) | (data & lane_mask(sel));
        mem_valid[key] = mem_valid[key] | sel;
        e = '{default: 0};
        e.addr = addr;
        bus_access(1'b1, addr, sel, data, e);
    endtask

    task automatic mem_read(input wb_addr_t addr);
        exp_rsp_t e;
        int       key;
        key = int'(addr >> 2);
        e = '{default: 0};
        e.addr = addr;
        if (mem_valid.exists(key))
        begin
            e.exp_rdata = mem_model[key];
            e.rd_mask   = lane_mask(mem_valid[key]);
        end
        bus_access(1'b0, addr, 4'hf, $urandom(), e);
    endtask

    task automatic err_access(input wb_addr_t addr);
        exp_rsp_t e;
        e = '{default: 0};
        e.addr    = addr;
        e.exp_err = 1'b1;
        bus_access($urandom_range(0, 1), addr, $urandom_range(0, 15), $urandom(), e);
    endtask

    task automatic reg_write(input wb_addr_t ofs, input wb_sel_t sel, input wb_data_t data);
        exp_rsp_t e;
        e = '{default: 0};
        e.addr = PERIPH_BASE + ofs;
        if (ofs == PERIPH_LED_OFS && sel[0])
            led_model = data[7:0];
        bus_access(1'b1, PERIPH_BASE + ofs, sel, data, e);
    endtask

    task automatic reg_read(input wb_addr_t ofs, input wb_data_t exp);
        exp_rsp_t e;
        e = '{default: 0};
        e.addr      = PERIPH_BASE + ofs;
        e.exp_rdata = exp;
        e.rd_mask   = '1;
        bus_access(1'b0, PERIPH_BASE + ofs, 4'hf, $urandom(), e);
    endtask

    // clustered near both region ends so words get hit more than once
    function automatic wb_addr_t random_mem_addr();
        int       words;
        int       idx;
        wb_addr_t base;
        if ($urandom_range(0, 1) == 0)
        begin
            base  = IMEM_BASE;
            words = 2**IMEM_SIZE_WORDS_POT;
        end
        else
        begin
            base  = DMEM_BASE;
            words = 2**DMEM_SIZE_WORDS_POT;
        end
        idx = $urandom_range(0, 15);
        if ($urandom_range(0, 1) == 1)
            idx = words - 1 - idx;
        return base + wb_addr_t'(idx * 4);
    endfunction

    function automatic wb_addr_t unmapped_addr();
        case ($urandom_range(0, 2))
            0:       return IMEM_BASE + 32'h1000 + wb_addr_t'($urandom_range(0, 255) * 4);
            1:       return PERIPH_BASE + 32'h1000 + wb_addr_t'($urandom_range(0, 255) * 4);
            default: return 32'h1000_0000 | ($urandom() & 32'hffff_fffc);
        endcase
    endfunction

    // responses are sampled at the falling edge, away from the bus edges
    always @(negedge sys_clk)
    begin : rsp_check
        exp_rsp_t e;
        if (reset_done && (wb_rsp.ack || wb_rsp.err))
        begin
            if (wb_rsp.ack && wb_rsp.err)
            begin
                $display("ack and err both high at cycle %0d", cycle_cnt);
                proto_errs++;
            end
            if (rsp_q.size() == 0)
            begin
                $display("response with no request in flight at cycle %0d", cycle_cnt);
                proto_errs++;
            end
            else
            begin
                e = rsp_q.pop_front();
                if (cycle_cnt != e.due)
                begin
                    $display("response for %h at cycle %0d, expected %0d",
                             e.addr, cycle_cnt, e.due);
                    proto_errs++;
                end
                if (wb_rsp.err !== e.exp_err)
                begin
                    $display("ERROR err at %h exp %h got %h", e.addr, e.exp_err, wb_rsp.err);
                    proto_errs++;
                end
                else if ((wb_rsp.rdata & e.rd_mask) !== (e.exp_rdata & e.rd_mask))
                begin
                    $display("ERROR rdata at %h exp %h got %h", e.addr,
                             e.exp_rdata & e.rd_mask, wb_rsp.rdata & e.rd_mask);
                    data_errs++;
                end
            end
        end
        else if (rsp_q.size() > 0 && rsp_q[0].due <= cycle_cnt)
        begin
            $display("no response for %h at cycle %0d", rsp_q[0].addr, cycle_cnt);
            proto_errs++;
            void'(rsp_q.pop_front());
        end
    end

    // 8N1 line decoder sampling each bit near its middle
    initial
    begin : uart_monitor
        int         idle_cycles;
        uart_byte_t rx;
        idle_cycles = 0;
        forever
        begin
            @(negedge sys_clk);
            if (reset_done && uart_tx === 1'b0)
            begin
                idle_cycles = 0;
                repeat (UART_CLKS_PER_BIT / 2 - 1) @(negedge sys_clk);
                if (uart_tx !== 1'b0)
                begin
                    $display("start bit too short");
                    uart_errs++;
                end
                for (int i = 0; i < 8; i++)
                begin
                    repeat (UART_CLKS_PER_BIT) @(negedge sys_clk);
                    rx[i] = uart_tx;
                end
                repeat (UART_CLKS_PER_BIT) @(negedge sys_clk);
                if (uart_tx !== 1'b1)
                begin
                    $display("stop bit missing");
                    uart_errs++;
                end
                if (uart_q.size() == 0)
                begin
                    $display("UART frame %h with no byte written", rx);
                    uart_errs++;
                end
                else if (rx !== uart_q[0])
                begin
                    $display("ERROR uart_tx_o byte exp %h got %h", uart_q[0], rx);
                    uart_errs++;
                    void'(uart_q.pop_front());
                end
                else
                begin
                    void'(uart_q.pop_front());
                end
            end
            else if (uart_q.size() > 0)
            begin
                idle_cycles++;
                if (idle_cycles > TIMEOUT_CYCLES)
                    report_timeout("a UART start bit");
            end
            else
            begin
                idle_cycles = 0;
            end
        end
    end

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while ((rsp_q.size() > 0 || uart_q.size() > 0) && waited < TIMEOUT_CYCLES)
        begin
            bus_idle(1);
            waited++;
        end
        if (rsp_q.size() > 0 || uart_q.size() > 0)
            report_timeout("responses and UART frames to drain");
    endtask

    task automatic check_reset_state();
        if (wb_rsp.ack !== 1'b0 || wb_rsp.err !== 1'b0 || wb_rsp.stall !== 1'b0)
        begin
            $display("ERROR wb_rsp_o flags exp 0 got ack %h err %h stall %h",
                     wb_rsp.ack, wb_rsp.err, wb_rsp.stall);
            proto_errs++;
        end
        if (led !== 8'h00)
        begin
            $display("ERROR led_o exp %h got %h", 8'h00, led);
            data_errs++;
        end
        if (uart_tx !== 1'b1)
        begin
            $display("ERROR uart_tx_o exp %h got %h", 1'b1, uart_tx);
            uart_errs++;
        end
    endtask

    task automatic run_mem_traffic();
        wb_addr_t addrs[$];
        wb_addr_t a;
        for (int i = 0; i < 40; i++)
        begin
            a = random_mem_addr();
            mem_write(a, $urandom_range(0, 15), $urandom());
            addrs.push_back(a);
        end
        foreach (addrs[i])
            mem_read(addrs[i]);
        bus_idle(2);
    endtask

    task automatic run_unmapped_mix();
        wb_addr_t addrs[$];
        wb_addr_t a;
        for (int i = 0; i < 30; i++)
        begin
            if ($urandom_range(0, 1) == 0)
            begin
                err_access(unmapped_addr());
            end
            else
            begin
                a = random_mem_addr();
                mem_write(a, $urandom_range(0, 15), $urandom());
                addrs.push_back(a);
            end
        end
        foreach (addrs[i])
        begin
            mem_read(addrs[i]);
            err_access(unmapped_addr());
        end
        bus_idle(2);
    endtask

    task automatic run_led();
        for (int i = 0; i < 12; i++)
        begin
            reg_write(PERIPH_LED_OFS, $urandom_range(0, 15), $urandom());
            bus_idle(1);
            if (led !== led_model)
            begin
                $display("ERROR led_o exp %h got %h", led_model, led);
                data_errs++;
            end
            reg_read(PERIPH_LED_OFS, wb_data_t'(led_model));
        end
        bus_idle(2);
    endtask

    task automatic run_uart();
        uart_byte_t b;
        for (int i = 0; i < 4; i++)
        begin
            b = uart_byte_t'($urandom());
            reg_write(PERIPH_UART_DATA_OFS, $urandom_range(0, 15) | 1, wb_data_t'(b));
            uart_q.push_back(b);
            // status read once the frame is on the line
            bus_idle(UART_CLKS_PER_BIT);
            reg_read(PERIPH_UART_STAT_OFS, 32'h1);
            // second byte lands while the first frame is still on the line
            b = uart_byte_t'($urandom());
            reg_write(PERIPH_UART_DATA_OFS, $urandom_range(0, 15) | 1, wb_data_t'(b));
            if (stall_cycles == 0)
            begin
                $display("UART data write during a frame was not stalled");
                proto_errs++;
            end
            uart_q.push_back(b);
            reg_read(PERIPH_UART_STAT_OFS, 32'h1);
        end
        wait_for_drain();
        bus_idle(2 * UART_CLKS_PER_BIT);
        reg_read(PERIPH_UART_STAT_OFS, 32'h0);
        bus_idle(2);
    endtask

    initial
    begin
        void'($urandom(32'h9701));
        arst_n_i  = 1'b0;
        wb_req    = '0;
        led_model = '0;
        repeat (16) @(posedge sys_clk);
        #1;
        arst_n_i = 1'b1;
        // synchronizer release plus margin
        repeat (RST_SYNC_STAGES + 2) @(posedge sys_clk);
        #1;
        check_reset_state();
        reset_done = 1'b1;
        run_mem_traffic();
        run_unmapped_mix();
        run_led();
        run_uart();
        wait_for_drain();
        end_run();
    end

endmodule : tb_soc_top

//--- soc_top.f
platform_pkg.sv
sp_mem_wb.sv
wb_decoder.sv
periph_regs.sv
uart_tx.sv
soc_top.sv
tb_soc_top.sv

//--- Bender.yml
package:
  name: soc_top

sources:
  - platform_pkg.sv
  - sp_mem_wb.sv
  - wb_decoder.sv
  - periph_regs.sv
  - uart_tx.sv
  - soc_top.sv
  - target: test
    files:
      - tb_soc_top.sv
